// ==== logic/permPkg.sv ====
package permPkg;

    // A truth table covers seven variables, variable k being bit k of the index
    localparam int TT_VARS = 7;
    localparam int TT_BITS = 1 << TT_VARS;

    // The popcount stage splits a truth table into bytes
    localparam int BYTE_LANES = TT_BITS / 8;

    // Identity plus the four swaps of variable 2 with variables 3 to 6
    localparam int NUM_LANES = 5;

    typedef logic [TT_BITS-1:0] truthTable_t;

    // Holds 0 up to 128 set bits
    typedef logic [7:0] popCount_t;

    // Popcount of a single byte, 0 up to 8
    typedef logic [3:0] byteCount_t;

    typedef struct packed {
        logic        valid;
        logic        batchDone;
        truthTable_t bot;
    } botBeat_t;

    // RUN takes bots, DRAIN waits for the batch marker to leave the
    // pipeline, DONE holds the totals until they are collected
    typedef enum logic [1:0] {
        LANE_RUN,
        LANE_DRAIN,
        LANE_DONE
    } laneState_t;

endpackage

// ==== logic/varSwap.sv ====
`timescale 1ns/1ps

module varSwap
    import permPkg::*;
#(
    parameter int SWAP_A = 2,
    parameter int SWAP_B = 3
) (
    input  logic     clk,
    input  logic     rstN,
    input  botBeat_t beatIn,
    output botBeat_t beatOut
);

    // Index with bits SWAP_A and SWAP_B exchanged. The mapping is its own
    // inverse, so it serves for both source and destination
    function automatic int swapIndex(input int idx);
        int result;
        result = idx;
        result[SWAP_A] = idx[SWAP_B];
        result[SWAP_B] = idx[SWAP_A];
        return result;
    endfunction

    truthTable_t swapped;

    for (genvar i = 0; i < TT_BITS; i++) begin : gBit
        assign swapped[i] = beatIn.bot[swapIndex(i)];
    end

    // The swapped table travels with its valid and batchDone flags through one stage
    always_ff @(posedge clk) begin
        beatOut.bot <= swapped;
        if (!rstN) begin
            beatOut.valid     <= 1'b0;
            beatOut.batchDone <= 1'b0;
        end else begin
            beatOut.valid     <= beatIn.valid;
            beatOut.batchDone <= beatIn.batchDone;
        end
    end

endmodule

// ==== logic/laneAccumulator.sv ====
`timescale 1ns/1ps

module laneAccumulator
    import permPkg::*;
#(
    parameter int COUNT_WIDTH = 16
) (
    input  logic                   clk,
    input  logic                   rstN,
    input  truthTable_t            top,
    input  botBeat_t               beat,
    input  logic                   clearLane,
    output logic [COUNT_WIDTH+7:0] laneSum,
    output logic [COUNT_WIDTH-1:0] laneCount,
    output logic                   laneDone
);

    typedef logic [COUNT_WIDTH+7:0] laneSum_t;
    typedef logic [COUNT_WIDTH-1:0] laneCount_t;

    function automatic byteCount_t countByte(input logic [7:0] value);
        byteCount_t ones;
        ones = '0;
        for (int k = 0; k < 8; k++) begin
            ones += byteCount_t'(value[k]);
        end
        return ones;
    endfunction

    truthTable_t masked;

    logic [BYTE_LANES-1:0][3:0] bytePopNext;
    logic [BYTE_LANES-1:0][3:0] bytePop;
    logic                       valid1;
    logic                       done1;

    popCount_t popTotalNext;
    popCount_t popTotal;
    logic      valid2;
    logic      done2;

    laneState_t laneState;

    assign masked = top & beat.bot;

    // Stage 1 counts the set bits of each byte of top AND bot
    always_comb begin
        for (int b = 0; b < BYTE_LANES; b++) begin
            bytePopNext[b] = countByte(masked[b*8 +: 8]);
        end
    end

    always_ff @(posedge clk) begin
        bytePop <= bytePopNext;
        if (!rstN) begin
            valid1 <= 1'b0;
            done1  <= 1'b0;
        end else begin
            valid1 <= beat.valid;
            done1  <= beat.batchDone;
        end
    end

    // Stage 2 folds the sixteen byte counts into one popcount
    always_comb begin
        popTotalNext = '0;
        for (int b = 0; b < BYTE_LANES; b++) begin
            popTotalNext += popCount_t'(bytePop[b]);
        end
    end

    always_ff @(posedge clk) begin
        popTotal <= popTotalNext;
        if (!rstN) begin
            valid2 <= 1'b0;
            done2  <= 1'b0;
        end else begin
            valid2 <= valid1;
            done2  <= done1;
        end
    end

    // Stage 3 accumulates and tracks the batch
    always_ff @(posedge clk) begin
        if (!rstN || clearLane) begin
            laneState <= LANE_RUN;
            laneSum   <= '0;
            laneCount <= '0;
        end else begin
            if (valid2) begin
                laneSum   <= laneSum + laneSum_t'(popTotal);
                laneCount <= laneCount + laneCount_t'(1);
            end
            case (laneState)
                LANE_RUN: begin
                    if (beat.batchDone) begin
                        laneState <= LANE_DRAIN;
                    end
                end
                LANE_DRAIN: begin
                    // The marker leaves stage 2 right behind the last bot
                    if (done2) begin
                        laneState <= LANE_DONE;
                    end
                end
                default: begin
                    laneState <= LANE_DONE;
                end
            endcase
        end
    end

    assign laneDone = (laneState == LANE_DONE);

endmodule

// ==== logic/sumTree5.sv ====
`timescale 1ns/1ps

module sumTree5
    import permPkg::*;
#(
    parameter int VALUE_WIDTH = 24
) (
    input  logic                                  clk,
    input  logic [NUM_LANES-1:0][VALUE_WIDTH-1:0] values,
    output logic [VALUE_WIDTH+2:0]                total
);

    typedef logic [VALUE_WIDTH-1:0] single_t;
    typedef logic [VALUE_WIDTH:0]   pair_t;
    typedef logic [VALUE_WIDTH+1:0] triple_t;
    typedef logic [VALUE_WIDTH+2:0] total_t;

    pair_t   sum01;
    pair_t   sum23;
    single_t value4D;

    pair_t   sum01D;
    triple_t sum234;

    // Stage 1 adds the two pairs while value 4 waits a cycle
    always_ff @(posedge clk) begin
        sum01   <= pair_t'(values[0]) + pair_t'(values[1]);
        sum23   <= pair_t'(values[2]) + pair_t'(values[3]);
        value4D <= values[4];
    end

    // Stage 2 keeps the tree balanced
    always_ff @(posedge clk) begin
        sum01D <= sum01;
        sum234 <= triple_t'(sum23) + triple_t'(value4D);
    end

    always_ff @(posedge clk) begin
        total <= total_t'(sum01D) + total_t'(sum234);
    end

endmodule

// ==== logic/permSumPack.sv ====
`timescale 1ns/1ps

module permSumPack
    import permPkg::*;
#(
    parameter int COUNT_WIDTH = 16
) (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    topLoad,
    input  truthTable_t             topIn,
    input  logic                    botValid,
    input  truthTable_t             bot,
    input  logic                    batchDone,
    input  logic                    grabResults,
    output logic                    resultsAvailable,
    output logic [COUNT_WIDTH+10:0] pcoeffSum,
    output logic [COUNT_WIDTH+2:0]  pcoeffCount
);

    // Matches the latency of sumTree5
    localparam int TREE_DELAY = 3;

    truthTable_t topReg;
    botBeat_t    inBeat;

    botBeat_t [NUM_LANES-1:0]                  laneBeats;
    logic     [NUM_LANES-1:0][COUNT_WIDTH+7:0] laneSums;
    logic     [NUM_LANES-1:0][COUNT_WIDTH-1:0] laneCounts;
    logic     [NUM_LANES-1:0]                  laneDone;

    logic                  allDone;
    logic [TREE_DELAY-1:0] doneDelay;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            topReg <= '0;
        end else if (topLoad) begin
            topReg <= topIn;
        end
    end

    assign inBeat = '{valid: botValid, batchDone: batchDone, bot: bot};

    // Identity lane gets one register so it lines up with the swap networks
    always_ff @(posedge clk) begin
        laneBeats[0].bot <= inBeat.bot;
        if (!rstN) begin
            laneBeats[0].valid     <= 1'b0;
            laneBeats[0].batchDone <= 1'b0;
        end else begin
            laneBeats[0].valid     <= inBeat.valid;
            laneBeats[0].batchDone <= inBeat.batchDone;
        end
    end

    // Lanes 1 to 4 swap variable 2 with variables 3 to 6
    for (genvar l = 1; l < NUM_LANES; l++) begin : gSwap
        varSwap #(
            .SWAP_A(2),
            .SWAP_B(l + 2)
        ) swapInst (
            .clk    (clk),
            .rstN   (rstN),
            .beatIn (inBeat),
            .beatOut(laneBeats[l])
        );
    end

    for (genvar l = 0; l < NUM_LANES; l++) begin : gLane
        laneAccumulator #(
            .COUNT_WIDTH(COUNT_WIDTH)
        ) laneInst (
            .clk      (clk),
            .rstN     (rstN),
            .top      (topReg),
            .beat     (laneBeats[l]),
            .clearLane(grabResults),
            .laneSum  (laneSums[l]),
            .laneCount(laneCounts[l]),
            .laneDone (laneDone[l])
        );
    end

    sumTree5 #(
        .VALUE_WIDTH(COUNT_WIDTH + 8)
    ) sumTree (
        .clk   (clk),
        .values(laneSums),
        .total (pcoeffSum)
    );

    sumTree5 #(
        .VALUE_WIDTH(COUNT_WIDTH)
    ) countTree (
        .clk   (clk),
        .values(laneCounts),
        .total (pcoeffCount)
    );

    assign allDone = &laneDone;

    // The done flag trails the lane totals through the trees. A grab flushes
    // it, or the stale ones would raise resultsAvailable again
    always_ff @(posedge clk) begin
        if (!rstN || grabResults) begin
            doneDelay        <= '0;
            resultsAvailable <= 1'b0;
        end else begin
            doneDelay        <= {doneDelay[TREE_DELAY-2:0], allDone};
            resultsAvailable <= doneDelay[TREE_DELAY-1];
        end
    end

endmodule

// ==== verif/permModel.svh ====
`ifndef PERM_MODEL_SVH
`define PERM_MODEL_SVH

// Entry i of a permuted table is the source entry whose index has the two
// variable bits exchanged
function automatic truthTable_t swapVars(input truthTable_t source, input int varA,
                                         input int varB);
    truthTable_t result;
    int          srcIdx;
    for (int i = 0; i < $bits(truthTable_t); i++) begin
        srcIdx = i;
        if (((i >> varA) & 1) != ((i >> varB) & 1)) begin
            srcIdx = i ^ ((1 << varA) | (1 << varB));
        end
        result[i] = source[srcIdx];
    end
    return result;
endfunction

function automatic int countOnes(input truthTable_t value);
    int ones;
    ones = 0;
    for (int i = 0; i < $bits(truthTable_t); i++) begin
        if (value[i]) begin
            ones++;
        end
    end
    return ones;
endfunction

// Identity first, then variable 2 against variables 3, 4, 5 and 6
function automatic pcoeffSum_t botContribution(input truthTable_t topValue,
                                               input truthTable_t botValue);
    pcoeffSum_t total;
    total = pcoeffSum_t'(countOnes(topValue & botValue));
    for (int partner = 3; partner <= 6; partner++) begin
        total += pcoeffSum_t'(countOnes(topValue & swapVars(botValue, 2, partner)));
    end
    return total;
endfunction

function automatic pcoeffSum_t batchSum(input truthTable_t topValue,
                                        input truthTable_t bots[$]);
    pcoeffSum_t total;
    total = '0;
    foreach (bots[n]) begin
        total += botContribution(topValue, bots[n]);
    end
    return total;
endfunction

// Each bot is counted once per permutation
function automatic pcoeffCount_t batchCount(input int numBots);
    return pcoeffCount_t'(5 * numBots);
endfunction

`endif

// ==== verif/permSumPackTb.sv ====
`timescale 1ns/1ps

module permSumPackTb
    import permPkg::*;
();

    localparam int COUNT_WIDTH = 16;

    localparam int ONES_BATCHES   = 2;
    localparam int ONES_BOTS      = 12;
    localparam int RANDOM_BATCHES = 4;
    localparam int RANDOM_SLOTS   = 24;
    localparam int TIMING_BOTS    = 6;
    localparam int HOLD_CYCLES    = 5;
    localparam int RELOAD_BATCHES = 3;
    localparam int RELOAD_BOTS    = 16;

    localparam int TOTAL_BOTS = ONES_BATCHES * ONES_BOTS + RANDOM_BATCHES * RANDOM_SLOTS
        + TIMING_BOTS + HOLD_CYCLES + RELOAD_BATCHES * RELOAD_BOTS;
    localparam int NUM_BATCHES = ONES_BATCHES + RANDOM_BATCHES + 2 + RELOAD_BATCHES;
    localparam int TIMEOUT_CYCLES = TOTAL_BOTS + 20 * NUM_BATCHES + 2;

    // Results are due 8 cycles after batchDone
    localparam int RESULT_WAIT = 12;

    typedef logic [COUNT_WIDTH+10:0] pcoeffSum_t;
    typedef logic [COUNT_WIDTH+2:0]  pcoeffCount_t;

    logic         clk = 1'b0;
    logic         rstN;
    logic         topLoad;
    truthTable_t  topIn;
    logic         botValid;
    truthTable_t  bot;
    logic         batchDone;
    logic         grabResults;
    logic         resultsAvailable;
    pcoeffSum_t   pcoeffSum;
    pcoeffCount_t pcoeffCount;

    logic [31:0] rngState = 32'd71006;
    int          cycleCount = 0;
    truthTable_t batchBots[$];

    `include "permModel.svh"

    permSumPack #(
        .COUNT_WIDTH(COUNT_WIDTH)
    ) permSumPack_inst (
        .clk             (clk),
        .rstN            (rstN),
        .topLoad         (topLoad),
        .topIn           (topIn),
        .botValid        (botValid),
        .bot             (bot),
        .batchDone       (batchDone),
        .grabResults     (grabResults),
        .resultsAvailable(resultsAvailable),
        .pcoeffSum       (pcoeffSum),
        .pcoeffCount     (pcoeffCount)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("tests failed");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [31:0] nextRandom();
        rngState = rngState * 32'd1664525 + 32'd1013904223;
        return rngState;
    endfunction

    function automatic truthTable_t randomTable();
        return {nextRandom(), nextRandom(), nextRandom(), nextRandom()};
    endfunction

    task automatic checkSum(input string name, input pcoeffSum_t expected,
                            input pcoeffSum_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t %s expected %0d actual %0d", $time, name, expected, actual);
            $display("tests failed");
            $fatal(1, "sum mismatch");
        end
    endtask

    task automatic checkCount(input string name, input pcoeffCount_t expected,
                              input pcoeffCount_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t %s expected %0d actual %0d", $time, name, expected, actual);
            $display("tests failed");
            $fatal(1, "count mismatch");
        end
    endtask

    task automatic checkLevel(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t %s expected %b actual %b", $time, name, expected, actual);
            $display("tests failed");
            $fatal(1, "level mismatch");
        end
    endtask

    task automatic applyInputs(input logic load, input truthTable_t topValue, input logic valid,
                               input truthTable_t botValue, input logic done, input logic grab);
        @(posedge clk);
        topLoad     <= load;
        topIn       <= topValue;
        botValid    <= valid;
        bot         <= botValue;
        batchDone   <= done;
        grabResults <= grab;
    endtask

    task automatic idleCycle();
        applyInputs(1'b0, '0, 1'b0, '0, 1'b0, 1'b0);
    endtask

    task automatic sendBot(input logic valid, input truthTable_t botValue);
        applyInputs(1'b0, '0, valid, botValue, 1'b0, 1'b0);
        if (valid) begin
            batchBots.push_back(botValue);
        end
    endtask

    task automatic waitResults();
        int waited;
        waited = 0;
        do begin
            idleCycle();
            @(negedge clk);
            waited++;
        end while (!resultsAvailable && waited < RESULT_WAIT);
        if (!resultsAvailable) begin
            $display("resultsAvailable stayed low for %0d cycles after batchDone", RESULT_WAIT);
            $display("tests failed");
            $fatal(1, "no results");
        end
    endtask

    // The flag is still high while the grab is on the wire and low one edge later
    task automatic collectResults();
        applyInputs(1'b0, '0, 1'b0, '0, 1'b0, 1'b1);
        @(negedge clk);
        checkLevel("resultsAvailable", 1'b1, resultsAvailable);
        idleCycle();
        @(negedge clk);
        checkLevel("resultsAvailable", 1'b0, resultsAvailable);
        batchBots.delete();
    endtask

    task automatic finishBatch(input pcoeffSum_t expSum, input pcoeffCount_t expCount);
        applyInputs(1'b0, '0, 1'b0, '0, 1'b1, 1'b0);
        waitResults();
        checkSum("pcoeffSum", expSum, pcoeffSum);
        checkCount("pcoeffCount", expCount, pcoeffCount);
        collectResults();
    endtask

    initial begin
        truthTable_t  topValue;
        truthTable_t  botValue;
        pcoeffSum_t   expSum;
        pcoeffCount_t expCount;
        logic [31:0]  draw;

        rstN        <= 1'b0;
        topLoad     <= 1'b0;
        topIn       <= '0;
        botValid    <= 1'b0;
        bot         <= '0;
        batchDone   <= 1'b0;
        grabResults <= 1'b0;
        repeat (2) @(posedge clk);
        rstN <= 1'b1;

        // A full top keeps every set bit, so each permutation adds the bot's popcount
        applyInputs(1'b1, '1, 1'b0, '0, 1'b0, 1'b0);
        for (int b = 0; b < ONES_BATCHES; b++) begin
            expSum = '0;
            for (int n = 0; n < ONES_BOTS; n++) begin
                botValue = randomTable();
                sendBot(1'b1, botValue);
                expSum += pcoeffSum_t'(5 * countOnes(botValue));
            end
            finishBatch(expSum, pcoeffCount_t'(5 * ONES_BOTS));
        end

        // Random top, botValid random per cycle with junk bots in the gaps
        for (int b = 0; b < RANDOM_BATCHES; b++) begin
            topValue = randomTable();
            applyInputs(1'b1, topValue, 1'b0, '0, 1'b0, 1'b0);
            for (int n = 0; n < RANDOM_SLOTS; n++) begin
                draw = nextRandom();
                sendBot(draw[20], randomTable());
            end
            finishBatch(batchSum(topValue, batchBots), batchCount(batchBots.size()));
        end

        finishBatch('0, '0);

        topValue = randomTable();
        applyInputs(1'b1, topValue, 1'b0, '0, 1'b0, 1'b0);
        repeat (TIMING_BOTS) sendBot(1'b1, randomTable());
        applyInputs(1'b0, '0, 1'b0, '0, 1'b1, 1'b0);
        for (int k = 1; k <= 8; k++) begin
            idleCycle();
            @(negedge clk);
            checkLevel("resultsAvailable", k == 8, resultsAvailable);
        end
        expSum   = batchSum(topValue, batchBots);
        expCount = batchCount(batchBots.size());
        repeat (HOLD_CYCLES) begin
            idleCycle();
            @(negedge clk);
            checkLevel("resultsAvailable", 1'b1, resultsAvailable);
            checkSum("pcoeffSum", expSum, pcoeffSum);
            checkCount("pcoeffCount", expCount, pcoeffCount);
        end
        collectResults();

        // New top per batch and bots on every cycle
        for (int b = 0; b < RELOAD_BATCHES; b++) begin
            topValue = randomTable();
            applyInputs(1'b1, topValue, 1'b0, '0, 1'b0, 1'b0);
            repeat (RELOAD_BOTS) sendBot(1'b1, randomTable());
            finishBatch(batchSum(topValue, batchBots), batchCount(batchBots.size()));
        end

        $display("all tests passed");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+verif
logic/permPkg.sv
logic/varSwap.sv
logic/laneAccumulator.sv
logic/sumTree5.sv
logic/permSumPack.sv
verif/permSumPackTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and scans the log
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
    --top-module permSumPackTb \
    -f vlog.f \
    -o simv

# The simulator exits non-zero on a failure, the log decides the verdict
./obj_dir/simv > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "tests failed" "$LOG"; then
    echo "Simulation FAILED, see $LOG"
    exit 1
fi
if ! grep -q "all tests passed" "$LOG"; then
    echo "Simulation ended without a verdict, see $LOG"
    exit 1
fi
echo "Simulation PASSED"
